//--- mask_alu_pkg.sv
package mask_alu_pkg;

  // vector register and scalar widths
  localparam int VLEN          = 128;
  localparam int VL_WIDTH      = $clog2(VLEN) + 1;
  localparam int XLEN          = 32;
  localparam int ROB_IDX_WIDTH = 4;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110
  } funct3_e;

  typedef enum logic [5:0] {
    VWXUNARY0 = 6'b010000,
    VMUNARY0  = 6'b010100,
    VMANDN    = 6'b011000,
    VMAND     = 6'b011001,
    VMOR      = 6'b011010,
    VMXOR     = 6'b011011,
    VMORN     = 6'b011100,
    VMNAND    = 6'b011101,
    VMNOR     = 6'b011110,
    VMXNOR    = 6'b011111
  } funct6_e;

  // sub-opcodes carried in the vs1 field
  typedef enum logic [4:0] {
    VMSBF  = 5'b00001,
    VMSOF  = 5'b00010,
    VMSIF  = 5'b00011,
    VCPOP  = 5'b10000,
    VFIRST = 5'b10001
  } vs1_op_e;

  typedef enum logic [3:0] {
    OP_NONE, OP_ANDN, OP_AND, OP_OR, OP_XOR, OP_ORN, OP_NAND, OP_NOR, OP_XNOR,
    OP_CPOP, OP_FIRST, OP_SBF, OP_SIF, OP_SOF
  } mask_op_e;

  typedef struct packed {
    logic [ROB_IDX_WIDTH-1:0] rob_entry;
    funct3_e                  funct3;
    funct6_e                  funct6;
    vs1_op_e                  vs1;
    logic                     vm;
    logic [VL_WIDTH-1:0]      vstart;
    logic [VL_WIDTH-1:0]      vl;
    logic [VLEN-1:0]          v0_data;
    logic                     v0_data_valid;
    logic [VLEN-1:0]          vd_data;
    logic                     vd_data_valid;
    logic [VLEN-1:0]          vs1_data;
    logic                     vs1_data_valid;
    logic [VLEN-1:0]          vs2_data;
    logic                     vs2_data_valid;
  } mask_uop_t;

  // keep bit set means the element takes vd
  typedef struct packed {
    mask_op_e                 op;
    logic [VLEN-1:0]          src2;
    logic [VLEN-1:0]          src1;
    logic [VLEN-1:0]          vd;
    logic [VLEN-1:0]          keep;
    logic [ROB_IDX_WIDTH-1:0] rob_entry;
    logic                     ignore_vta;
    logic                     ignore_vma;
  } mask_exec_t;

  typedef struct packed {
    logic [ROB_IDX_WIDTH-1:0] rob_entry;
    logic [VLEN-1:0]          w_data;
    logic                     ignore_vta;
    logic                     ignore_vma;
  } mask_result_t;

endpackage

//--- mask_alu_decode.sv
`timescale 1ns/1ps

module mask_alu_decode (
  input  mask_alu_pkg::mask_uop_t  uop,
  output mask_alu_pkg::mask_exec_t exec
);
  import mask_alu_pkg::*;

  mask_op_e        op;
  logic            is_logic;
  logic            is_reduce;
  logic            is_setfirst;
  logic [VLEN-1:0] tail;
  logic [VLEN-1:0] prestart;
  logic [VLEN-1:0] active;

  // element masks from vl and vstart
  always_comb begin
    for (int i = 0; i < VLEN; i++) begin
      tail[i]     = i < int'(uop.vl);
      prestart[i] = i < int'(uop.vstart);
    end
  end

  always_comb begin
    op = OP_NONE;
    if (uop.funct3 == OPMVV) begin
      case (uop.funct6)
        VMANDN: op = OP_ANDN;
        VMAND:  op = OP_AND;
        VMOR:   op = OP_OR;
        VMXOR:  op = OP_XOR;
        VMORN:  op = OP_ORN;
        VMNAND: op = OP_NAND;
        VMNOR:  op = OP_NOR;
        VMXNOR: op = OP_XNOR;
        VWXUNARY0: begin
          case (uop.vs1)
            VCPOP:   op = OP_CPOP;
            VFIRST:  op = OP_FIRST;
            default: op = OP_NONE;
          endcase
        end
        VMUNARY0: begin
          case (uop.vs1)
            VMSBF:   op = OP_SBF;
            VMSIF:   op = OP_SIF;
            VMSOF:   op = OP_SOF;
            default: op = OP_NONE;
          endcase
        end
        default: op = OP_NONE;
      endcase
    end
  end

  assign is_logic    = op inside {OP_ANDN, OP_AND, OP_OR, OP_XOR,
                                  OP_ORN, OP_NAND, OP_NOR, OP_XNOR};
  assign is_reduce   = op inside {OP_CPOP, OP_FIRST};
  assign is_setfirst = op inside {OP_SBF, OP_SIF, OP_SOF};

  // body elements that count for reductions and set-first
  assign active = uop.vm ? tail : (tail & uop.v0_data);

  always_comb begin
    exec           = '0;
    exec.op        = op;
    exec.vd        = uop.vd_data;
    exec.rob_entry = uop.rob_entry;
    if (is_logic) begin
      exec.src2       = uop.vs2_data;
      exec.src1       = uop.vs1_data;
      exec.keep       = prestart;
      exec.ignore_vta = 1'b1;
    end else if (is_reduce) begin
      exec.src2 = uop.vs2_data & active;
    end else if (is_setfirst) begin
      exec.src2       = uop.vs2_data & active;
      // masked-off body elements hold their old value
      exec.keep       = uop.vm ? '0 : (tail & ~uop.v0_data);
      exec.ignore_vta = 1'b1;
      exec.ignore_vma = 1'b1;
    end
  end

endmodule

//--- mask_logic_ops.sv
`timescale 1ns/1ps

module mask_logic_ops (
  input  mask_alu_pkg::mask_exec_t            exec,
  output logic [mask_alu_pkg::VLEN-1:0]       logic_word
);
  import mask_alu_pkg::*;

  logic [VLEN-1:0] a;
  logic [VLEN-1:0] b;

  // operand order follows the opcode name, vs2 first
  assign a = exec.src2;
  assign b = exec.src1;

  always_comb begin
    case (exec.op)
      OP_ANDN: begin
        logic_word = a & ~b;
      end
      OP_AND: begin
        logic_word = a & b;
      end
      OP_OR: begin
        logic_word = a | b;
      end
      OP_XOR: begin
        logic_word = a ^ b;
      end
      OP_ORN: begin
        logic_word = a | ~b;
      end
      OP_NAND: begin
        logic_word = ~(a & b);
      end
      OP_NOR: begin
        logic_word = ~(a | b);
      end
      OP_XNOR: begin
        logic_word = ~(a ^ b);
      end
      default: begin
        logic_word = '0;
      end
    endcase
  end

endmodule

//--- mask_scan_ops.sv
`timescale 1ns/1ps

module mask_scan_ops (
  input  mask_alu_pkg::mask_exec_t            exec,
  output logic [mask_alu_pkg::VLEN-1:0]       scan_word
);
  import mask_alu_pkg::*;

  localparam int NCHUNK = VLEN / 16;
  localparam int LEVELS = $clog2(NCHUNK);
  localparam int CNT_W  = $clog2(VLEN + 1);

  logic [VLEN-1:0]  src;
  logic [VLEN-1:0]  first1;
  logic [VLEN-1:0]  before_first;
  logic [VLEN-1:0]  vmsbf_word;
  logic [VLEN-1:0]  vmsif_word;
  logic [VLEN-1:0]  vmsof_word;
  logic [VLEN-1:0]  vfirst_word;
  logic [XLEN-1:0]  first_idx;
  logic [XLEN-1:0]  cpop;
  logic [CNT_W-1:0] tree [LEVELS+1][NCHUNK];

  function automatic logic [4:0] pop16(input logic [15:0] bits);
    logic [4:0] sum;
    sum = '0;
    for (int b = 0; b < 16; b++) begin
      sum = sum + 5'(bits[b]);
    end
    return sum;
  endfunction

  assign src = exec.src2;

  // lowest set bit isolated or zero for a zero src
  assign first1       = src & (~src + 1'b1);
  // wraps to all ones for a zero source
  assign before_first = first1 - 1'b1;

  assign vmsbf_word = before_first;
  assign vmsif_word = before_first | first1;
  assign vmsof_word = first1;

  // one-hot to index
  always_comb begin
    first_idx = '0;
    for (int i = 0; i < VLEN; i++) begin
      if (first1[i]) begin
        first_idx = XLEN'(i);
      end
    end
  end

  assign vfirst_word = (src == '0) ? '1 : VLEN'(first_idx);

  // per-chunk counts then a pairwise adder tree
  always_comb begin
    tree = '{default: '0};
    for (int c = 0; c < NCHUNK; c++) begin
      tree[0][c] = CNT_W'(pop16(src[c*16 +: 16]));
    end
    for (int l = 0; l < LEVELS; l++) begin
      for (int n = 0; n < (NCHUNK >> (l + 1)); n++) begin
        tree[l+1][n] = tree[l][2*n] + tree[l][2*n+1];
      end
    end
  end

  assign cpop = XLEN'(tree[LEVELS][0]);

  always_comb begin
    case (exec.op)
      OP_CPOP:  scan_word = VLEN'(cpop);
      OP_FIRST: scan_word = vfirst_word;
      OP_SBF:   scan_word = vmsbf_word;
      OP_SIF:   scan_word = vmsif_word;
      OP_SOF:   scan_word = vmsof_word;
      default:  scan_word = '0;
    endcase
  end

endmodule

//--- mask_alu_retire.sv
`timescale 1ns/1ps

module mask_alu_retire #(
  parameter int CREDITS = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             accept,
  output logic                             uop_ready,
  input  logic                             credit_return,
  input  mask_alu_pkg::mask_exec_t         exec,
  input  logic [mask_alu_pkg::VLEN-1:0]    logic_word,
  input  logic [mask_alu_pkg::VLEN-1:0]    scan_word,
  output logic                             result_valid,
  output mask_alu_pkg::mask_result_t       result
);
  import mask_alu_pkg::*;

  localparam int CNT_W = $clog2(CREDITS + 1);

  logic [VLEN-1:0]  sel_word;
  logic [VLEN-1:0]  merged;
  logic [CNT_W-1:0] credit_cnt;

  always_comb begin
    case (exec.op)
      OP_CPOP, OP_FIRST, OP_SBF, OP_SIF, OP_SOF: sel_word = scan_word;
      default:                                   sel_word = logic_word;
    endcase
  end

  // old destination wins where keep is set
  assign merged = (sel_word & ~exec.keep) | (exec.vd & exec.keep);

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      result.rob_entry  <= exec.rob_entry;
      result.w_data     <= merged;
      result.ignore_vta <= exec.ignore_vta;
      result.ignore_vma <= exec.ignore_vma;
    end
  end

  // one credit per reorder buffer slot
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= CNT_W'(CREDITS);
    end else if (accept && !credit_return) begin
      credit_cnt <= credit_cnt - 1'b1;
    end else if (credit_return && !accept) begin
      credit_cnt <= credit_cnt + 1'b1;
    end
  end

  assign uop_ready = credit_cnt != '0;

  a_no_accept_without_credit: assert property (
    @(posedge clk) disable iff (rst) accept |-> credit_cnt != '0
  );

  // more returns than grants would push the count past its start
  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst) credit_cnt <= CNT_W'(CREDITS)
  );

endmodule

//--- mask_alu_unit.sv
`timescale 1ns/1ps

module mask_alu_unit #(
  parameter int CREDITS = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        uop_valid,
  input  mask_alu_pkg::mask_uop_t     uop,
  output logic                        uop_ready,
  output logic                        result_valid,
  output mask_alu_pkg::mask_result_t  result,
  input  logic                        credit_return
);
  import mask_alu_pkg::*;

  logic            accept;
  mask_exec_t      exec;
  logic [VLEN-1:0] logic_word;
  logic [VLEN-1:0] scan_word;

  assign accept = uop_valid & uop_ready;

  mask_alu_decode u_decode (
    .uop  (uop),
    .exec (exec)
  );

  mask_logic_ops u_logic_ops (
    .exec       (exec),
    .logic_word (logic_word)
  );

  mask_scan_ops u_scan_ops (
    .exec      (exec),
    .scan_word (scan_word)
  );

  mask_alu_retire #(
    .CREDITS (CREDITS)
  ) u_retire (
    .clk           (clk),
    .rst           (rst),
    .accept        (accept),
    .uop_ready     (uop_ready),
    .credit_return (credit_return),
    .exec          (exec),
    .logic_word    (logic_word),
    .scan_word     (scan_word),
    .result_valid  (result_valid),
    .result        (result)
  );

  // operand contracts from the reservation station at acceptance
  a_logic_operands: assert property (
    @(posedge clk) disable iff (rst)
    accept && (exec.op inside {OP_ANDN, OP_AND, OP_OR, OP_XOR,
                               OP_ORN, OP_NAND, OP_NOR, OP_XNOR})
    |-> uop.vm && uop.vs1_data_valid && uop.vs2_data_valid && uop.vd_data_valid
  );

  a_unary_operands: assert property (
    @(posedge clk) disable iff (rst)
    accept && (exec.op inside {OP_CPOP, OP_FIRST, OP_SBF, OP_SIF, OP_SOF})
    |-> !uop.vs1_data_valid && uop.vs2_data_valid
  );

  a_mask_operand: assert property (
    @(posedge clk) disable iff (rst)
    accept && (exec.op != OP_NONE) && !uop.vm |-> uop.v0_data_valid
  );

endmodule

//--- tb_mask_alu.sv
`timescale 1ns/1ps

module tb_mask_alu;
  import mask_alu_pkg::*;

  localparam int CREDITS = 2;
  localparam int NUM_UOPS = 25;
  // up to two cycles per micro-op, plus reset and the stall test
  localparam int TEST_CYCLES = NUM_UOPS * 2 + 20;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                     clk;
  logic                     rst;
  logic                     uop_valid;
  mask_uop_t                uop;
  logic                     uop_ready;
  logic                     result_valid;
  mask_result_t             result;
  logic                     credit_return;

  integer                   seed;
  int                       errors;
  int                       cycle_count;
  logic                     auto_return;
  logic                     pending_return;
  logic                     force_return;
  logic [ROB_IDX_WIDTH-1:0] next_rob;

  always #50 clk = ~clk;

  mask_alu_unit #(
    .CREDITS (CREDITS)
  ) UUT (
    .clk           (clk),
    .rst           (rst),
    .uop_valid     (uop_valid),
    .uop           (uop),
    .uop_ready     (uop_ready),
    .result_valid  (result_valid),
    .result        (result),
    .credit_return (credit_return)
  );

  // one clock with inputs driven 10 ns after the edge
  task automatic tick();
    @(posedge clk);
    #10;
    credit_return = pending_return | force_return;
    pending_return = auto_return & result_valid;
  endtask

  task automatic check_value(input string name, input logic [VLEN-1:0] expected,
                             input logic [VLEN-1:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [VLEN-1:0] rand_word();
    logic [VLEN-1:0] w;
    for (int k = 0; k < VLEN / 32; k++) begin
      w[k*32 +: 32] = $random(seed);
    end
    return w;
  endfunction

  function automatic mask_uop_t base_uop(input funct6_e f6, input vs1_op_e v1, input logic vm);
    mask_uop_t u;
    u = '0;
    u.rob_entry = next_rob;
    u.funct3 = OPMVV;
    u.funct6 = f6;
    u.vs1 = v1;
    u.vm = vm;
    u.vl = VL_WIDTH'(VLEN);
    u.v0_data = rand_word();
    u.v0_data_valid = 1'b1;
    u.vd_data = rand_word();
    u.vd_data_valid = 1'b1;
    u.vs1_data = rand_word();
    u.vs2_data = rand_word();
    u.vs2_data_valid = 1'b1;
    return u;
  endfunction

  function automatic logic [VLEN-1:0] expect_logic(input funct6_e f6, input logic [VLEN-1:0] vs2,
                                                   input logic [VLEN-1:0] vs1,
                                                   input logic [VLEN-1:0] vd, input int vstart);
    logic [VLEN-1:0] r;
    logic x;
    logic y;
    for (int i = 0; i < VLEN; i++) begin
      x = vs2[i];
      y = vs1[i];
      case (f6)
        VMANDN:  r[i] = x & !y;
        VMAND:   r[i] = x & y;
        VMOR:    r[i] = x | y;
        VMXOR:   r[i] = x ^ y;
        VMORN:   r[i] = x | !y;
        VMNAND:  r[i] = !(x & y);
        VMNOR:   r[i] = !(x | y);
        default: r[i] = !(x ^ y);
      endcase
      if (i < vstart) begin
        r[i] = vd[i];
      end
    end
    return r;
  endfunction

  // body elements of vs2 that the op looks at
  function automatic logic [VLEN-1:0] active_src(input mask_uop_t u);
    logic [VLEN-1:0] a;
    for (int i = 0; i < VLEN; i++) begin
      a[i] = u.vs2_data[i] && (i < int'(u.vl)) && (u.vm || u.v0_data[i]);
    end
    return a;
  endfunction

  function automatic logic [VLEN-1:0] expect_cpop(input mask_uop_t u);
    logic [VLEN-1:0] a;
    int cnt;
    a = active_src(u);
    cnt = 0;
    for (int i = 0; i < VLEN; i++) begin
      cnt += int'(a[i]);
    end
    return VLEN'(cnt);
  endfunction

  function automatic int first_index(input mask_uop_t u);
    logic [VLEN-1:0] a;
    int f;
    a = active_src(u);
    f = VLEN;
    for (int i = VLEN - 1; i >= 0; i--) begin
      if (a[i]) begin
        f = i;
      end
    end
    return f;
  endfunction

  function automatic logic [VLEN-1:0] expect_first(input mask_uop_t u);
    int f;
    f = first_index(u);
    return (f == VLEN) ? '1 : VLEN'(f);
  endfunction

  function automatic logic [VLEN-1:0] expect_set_first(input mask_uop_t u);
    logic [VLEN-1:0] r;
    int f;
    f = first_index(u);
    for (int i = 0; i < VLEN; i++) begin
      case (u.vs1)
        VMSBF:   r[i] = i < f;
        VMSIF:   r[i] = i <= f;
        default: r[i] = i == f;
      endcase
      if (!u.vm && (i < int'(u.vl)) && !u.v0_data[i]) begin
        r[i] = u.vd_data[i];
      end
    end
    return r;
  endfunction

  // waits for uop_ready, then expects the result one cycle after acceptance
  task automatic run_uop(input string name, input mask_uop_t u, input logic [VLEN-1:0] exp_word,
                         input logic exp_vta, input logic exp_vma);
    uop = u;
    uop_valid = 1'b1;
    while (!uop_ready) begin
      tick();
    end
    tick();
    uop_valid = 1'b0;
    check_value({name, " result_valid"}, VLEN'(1), VLEN'(result_valid));
    check_value({name, " w_data"}, exp_word, result.w_data);
    check_value({name, " rob_entry"}, VLEN'(u.rob_entry), VLEN'(result.rob_entry));
    check_value({name, " ignore_vta"}, VLEN'(exp_vta), VLEN'(result.ignore_vta));
    check_value({name, " ignore_vma"}, VLEN'(exp_vma), VLEN'(result.ignore_vma));
    next_rob = next_rob + 1'b1;
  endtask

  task automatic test_reset_state();
    check_value("reset result_valid", '0, VLEN'(result_valid));
    check_value("reset uop_ready", VLEN'(1), VLEN'(uop_ready));
  endtask

  task automatic test_logic_ops();
    funct6_e   ops [8];
    mask_uop_t u;
    int        vstart;
    ops = '{VMANDN, VMAND, VMOR, VMXOR, VMORN, VMNAND, VMNOR, VMXNOR};
    foreach (ops[k]) begin
      // vs1 is a register number here, not a sub-opcode
      u = base_uop(ops[k], vs1_op_e'(5'($random(seed))), 1'b1);
      u.vs1_data_valid = 1'b1;
      vstart = $unsigned($random(seed)) % VLEN;
      u.vstart = VL_WIDTH'(vstart);
      run_uop($sformatf("logic %s", ops[k].name()), u,
              expect_logic(ops[k], u.vs2_data, u.vs1_data, u.vd_data, vstart), 1'b1, 1'b0);
    end
  endtask

  task automatic test_reductions();
    mask_uop_t u;
    for (int m = 0; m < 2; m++) begin
      u = base_uop(VWXUNARY0, VCPOP, m == 0);
      u.vl = VL_WIDTH'(1 + $unsigned($random(seed)) % VLEN);
      run_uop($sformatf("vcpop %s", m ? "masked" : "unmasked"), u, expect_cpop(u), 1'b0, 1'b0);
      u = base_uop(VWXUNARY0, VFIRST, m == 0);
      u.vs2_data = u.vs2_data & rand_word() & rand_word();
      u.vl = VL_WIDTH'(1 + $unsigned($random(seed)) % VLEN);
      run_uop($sformatf("vfirst %s", m ? "masked" : "unmasked"), u, expect_first(u), 1'b0, 1'b0);
    end
    u = base_uop(VWXUNARY0, VFIRST, 1'b1);
    u.vs2_data = '0;
    run_uop("vfirst zero source", u, expect_first(u), 1'b0, 1'b0);
  endtask

  task automatic test_set_first();
    vs1_op_e   ops [3];
    mask_uop_t u;
    ops = '{VMSBF, VMSIF, VMSOF};
    foreach (ops[k]) begin
      // unmasked, masked, masked with zero source
      for (int m = 0; m < 3; m++) begin
        u = base_uop(VMUNARY0, ops[k], m == 0);
        u.vs2_data = (m == 2) ? '0 : (u.vs2_data & rand_word() & rand_word());
        u.vl = VL_WIDTH'(1 + $unsigned($random(seed)) % VLEN);
        run_uop($sformatf("%s case %0d", ops[k].name(), m), u, expect_set_first(u), 1'b1, 1'b1);
      end
    end
  endtask

  task automatic test_back_pressure();
    mask_uop_t a;
    mask_uop_t b;
    mask_uop_t c;
    // let outstanding credits drain back first
    repeat (3) tick();
    check_value("stall start uop_ready", VLEN'(1), VLEN'(uop_ready));
    auto_return = 1'b0;
    a = base_uop(VMXOR, VCPOP, 1'b1);
    a.vs1_data_valid = 1'b1;
    next_rob = next_rob + 1'b1;
    b = base_uop(VWXUNARY0, VCPOP, 1'b1);
    next_rob = next_rob + 1'b1;
    c = base_uop(VMUNARY0, VMSIF, 1'b0);
    next_rob = next_rob + 1'b1;
    uop = a;
    uop_valid = 1'b1;
    tick();
    check_value("stall a result_valid", VLEN'(1), VLEN'(result_valid));
    check_value("stall a w_data", expect_logic(VMXOR, a.vs2_data, a.vs1_data, a.vd_data, 0),
                result.w_data);
    uop = b;
    tick();
    check_value("stall b result_valid", VLEN'(1), VLEN'(result_valid));
    check_value("stall b w_data", expect_cpop(b), result.w_data);
    check_value("stall b uop_ready", '0, VLEN'(uop_ready));
    uop = c;
    repeat (2) begin
      tick();
      check_value("stall held result_valid", '0, VLEN'(result_valid));
      check_value("stall held uop_ready", '0, VLEN'(uop_ready));
    end
    force_return = 1'b1;
    tick();
    force_return = 1'b0;
    tick();
    check_value("stall return uop_ready", VLEN'(1), VLEN'(uop_ready));
    check_value("stall return result_valid", '0, VLEN'(result_valid));
    auto_return = 1'b1;
    tick();
    uop_valid = 1'b0;
    check_value("stall c result_valid", VLEN'(1), VLEN'(result_valid));
    check_value("stall c w_data", expect_set_first(c), result.w_data);
    check_value("stall c rob_entry", VLEN'(c.rob_entry), VLEN'(result.rob_entry));
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    uop_valid = 1'b0;
    uop = '0;
    credit_return = 1'b0;
    seed = 55446;
    errors = 0;
    auto_return = 1'b1;
    pending_return = 1'b0;
    force_return = 1'b0;
    next_rob = '0;
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;
    test_reset_state();
    test_logic_ops();
    test_reductions();
    test_set_first();
    test_back_pressure();
    tick();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- compile.f
mask_alu_pkg.sv
mask_alu_decode.sv
mask_logic_ops.sv
mask_scan_ops.sv
mask_alu_retire.sv
mask_alu_unit.sv
tb_mask_alu.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_mask_alu

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mask_alu -f compile.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
  exit 0
fi
exit 1
